// ==== logic/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  parameter int BUS_ADDR_W = 32;
  parameter int BUS_DATA_W = 32;
  parameter int BUS_MASK_W = BUS_DATA_W / 8;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  // One-cycle request strobe with its payload
  typedef struct packed {
    logic                  req;
    bus_op_e               op;
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_DATA_W-1:0] wdata;
    logic [BUS_MASK_W-1:0] wr_mask;
  } bus_req_t;

  // Ack comes one cycle after req, rdata valid with it
  typedef struct packed {
    logic                  ack;
    logic [BUS_DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== logic/soc_map_pkg.sv ====
`default_nettype none

package soc_map_pkg;

  // Top two address bits pick the target
  typedef enum logic [1:0] {
    TGT_MEM  = 2'b00,
    TGT_NONE = 2'b01,
    TGT_LED  = 2'b10,
    TGT_KEYS = 2'b11
  } target_e;

  parameter logic [31:0] MEM_BASE  = 32'h0000_0000;
  parameter logic [31:0] LED_BASE  = 32'h8000_0000;
  parameter logic [31:0] KEYS_BASE = 32'hC000_0000;

  parameter int LED_W = 8;

  // Key region registers
  parameter logic [31:0] KEY_LEVEL_OFS = 32'h0000_0000;
  parameter logic [31:0] KEY_PRESS_OFS = 32'h0000_0004;

endpackage

`default_nettype wire

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  logic                  clk,
  input  logic                  i_rst,

  input  bus_pkg::bus_req_t     i_req,
  output bus_pkg::bus_rsp_t     o_rsp,

  output bus_pkg::bus_req_t     o_mem_req,
  input  bus_pkg::bus_rsp_t     i_mem_rsp,

  output bus_pkg::bus_req_t     o_led_req,
  input  bus_pkg::bus_rsp_t     i_led_rsp,

  output bus_pkg::bus_req_t     o_key_req,
  input  bus_pkg::bus_rsp_t     i_key_rsp
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  target_e    tgt;
  target_e    tgt_q;
  logic       none_ack_q;
  logic [1:0] top_bits;

  assign top_bits = i_req.addr[BUS_ADDR_W-1 -: 2];

  always_comb
  begin
    if (top_bits == MEM_BASE[31:30])
      tgt = TGT_MEM;
    else if (top_bits == LED_BASE[31:30])
      tgt = TGT_LED;
    else if (top_bits == KEYS_BASE[31:30])
      tgt = TGT_KEYS;
    else
      tgt = TGT_NONE;
  end

  // Payload goes to everyone, strobe only to the chosen target
  always_comb
  begin
    o_mem_req     = i_req;
    o_led_req     = i_req;
    o_key_req     = i_req;
    o_mem_req.req = i_req.req && (tgt == TGT_MEM);
    o_led_req.req = i_req.req && (tgt == TGT_LED);
    o_key_req.req = i_req.req && (tgt == TGT_KEYS);
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      tgt_q      <= TGT_NONE;
      none_ack_q <= 1'b0;
    end
    else
    begin
      if (i_req.req)
        tgt_q <= tgt;
      // Unmapped accesses are answered here
      none_ack_q <= i_req.req && (tgt == TGT_NONE);
    end
  end

  always_comb
  begin
    case (tgt_q)
      TGT_MEM:  o_rsp = i_mem_rsp;
      TGT_LED:  o_rsp = i_led_rsp;
      TGT_KEYS: o_rsp = i_key_rsp;
      default:
      begin
        o_rsp.ack   = none_ack_q;
        o_rsp.rdata = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/soc_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_mem #(
  parameter int MEM_ADDR_BITS = 12
) (
  input  logic                  clk,

  input  bus_pkg::bus_req_t     i_ireq,
  output bus_pkg::bus_rsp_t     o_irsp,

  input  bus_pkg::bus_req_t     i_dreq,
  output bus_pkg::bus_rsp_t     o_drsp
);

  import bus_pkg::*;

  localparam int DEPTH = 2 ** MEM_ADDR_BITS;

  logic [BUS_DATA_W-1:0]    mem [DEPTH];

  logic [MEM_ADDR_BITS-1:0] iaddr;
  logic [MEM_ADDR_BITS-1:0] daddr;

  logic                     iack_q;
  logic [BUS_DATA_W-1:0]    irdata_q;
  logic                     dack_q;
  logic [BUS_DATA_W-1:0]    drdata_q;

  // Word index, upper bits of the region wrap
  assign iaddr = i_ireq.addr[MEM_ADDR_BITS+1:2];
  assign daddr = i_dreq.addr[MEM_ADDR_BITS+1:2];

  // Instruction fetch port
  always_ff @(posedge clk)
  begin
    iack_q <= i_ireq.req;
    if (i_ireq.req)
      irdata_q <= mem[iaddr];
  end

  // Data port, byte-masked write
  always_ff @(posedge clk)
  begin
    dack_q <= i_dreq.req;
    if (i_dreq.req)
    begin
      if (i_dreq.op == OP_WRITE)
      begin
        for (int i = 0; i < BUS_MASK_W; i++)
        begin
          if (i_dreq.wr_mask[i])
            mem[daddr][8*i +: 8] <= i_dreq.wdata[8*i +: 8];
        end
        drdata_q <= '0;
      end
      else
      begin
        drdata_q <= mem[daddr];
      end
    end
  end

  assign o_irsp.ack   = iack_q;
  assign o_irsp.rdata = irdata_q;
  assign o_drsp.ack   = dack_q;
  assign o_drsp.rdata = drdata_q;

endmodule

`default_nettype wire

// ==== logic/led_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_port (
  input  logic                          clk,
  input  logic                          i_rst,

  input  bus_pkg::bus_req_t             i_req,
  output bus_pkg::bus_rsp_t             o_rsp,

  output logic [soc_map_pkg::LED_W-1:0] o_led
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic [LED_W-1:0]      led_q;
  logic                  ack_q;
  logic [BUS_DATA_W-1:0] rdata_q;
  logic                  wr_en;

  // One register for the whole region, lane 0 only
  assign wr_en = i_req.req && (i_req.op == OP_WRITE) && i_req.wr_mask[0];

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      led_q <= '0;
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= i_req.req;
      if (wr_en)
        led_q <= i_req.wdata[LED_W-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_req.req)
    begin
      if (i_req.op == OP_READ)
        rdata_q <= BUS_DATA_W'(led_q);
      else
        rdata_q <= '0;
    end
  end

  assign o_rsp.ack   = ack_q;
  assign o_rsp.rdata = rdata_q;
  assign o_led       = led_q;

endmodule

`default_nettype wire

// ==== logic/key_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_port #(
  parameter int NUM_KEYS = 2
) (
  input  logic                  clk,
  input  logic                  i_rst,

  input  logic [NUM_KEYS-1:0]   i_key,

  input  bus_pkg::bus_req_t     i_req,
  output bus_pkg::bus_rsp_t     o_rsp
);

  import bus_pkg::*;
  import soc_map_pkg::*;

  logic [NUM_KEYS-1:0]   key_sync1;
  logic [NUM_KEYS-1:0]   key_sync2;
  logic [NUM_KEYS-1:0]   key_prev;
  logic [NUM_KEYS-1:0]   press_q;
  logic [NUM_KEYS-1:0]   rising;
  logic [NUM_KEYS-1:0]   clr;
  logic                  sel_level;
  logic                  sel_press;
  logic                  ack_q;
  logic [BUS_DATA_W-1:0] rdata_q;

  assign sel_level = (i_req.addr[2] == KEY_LEVEL_OFS[2]);
  assign sel_press = (i_req.addr[2] == KEY_PRESS_OFS[2]);

  assign rising = key_sync2 & ~key_prev;

  // Write 1 to clear, lane 0 carries the key bits
  always_comb
  begin
    clr = '0;
    if (i_req.req && (i_req.op == OP_WRITE) && sel_press && i_req.wr_mask[0])
      clr = i_req.wdata[NUM_KEYS-1:0];
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      key_sync1 <= '0;
      key_sync2 <= '0;
      key_prev  <= '0;
      press_q   <= '0;
      ack_q     <= 1'b0;
    end
    else
    begin
      // Keys are active low on the pins
      key_sync1 <= ~i_key;
      key_sync2 <= key_sync1;
      key_prev  <= key_sync2;
      // New press wins over a clear
      press_q   <= (press_q & ~clr) | rising;
      ack_q     <= i_req.req;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_req.req)
    begin
      if (i_req.op == OP_WRITE)
        rdata_q <= '0;
      else if (sel_level)
        rdata_q <= BUS_DATA_W'(key_sync2);
      else
        rdata_q <= BUS_DATA_W'(press_q);
    end
  end

  assign o_rsp.ack   = ack_q;
  assign o_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== logic/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
  parameter int MEM_ADDR_BITS = 12,
  parameter int NUM_KEYS      = 2
) (
  input  logic                          clk,
  input  logic                          i_rst,

  input  bus_pkg::bus_req_t             i_ibus,
  output bus_pkg::bus_rsp_t             o_ibus,

  input  bus_pkg::bus_req_t             i_dbus,
  output bus_pkg::bus_rsp_t             o_dbus,

  input  logic [NUM_KEYS-1:0]           i_key,
  output logic [soc_map_pkg::LED_W-1:0] o_led
);

  import bus_pkg::*;

  bus_req_t mem_req;
  bus_rsp_t mem_rsp;
  bus_req_t led_req;
  bus_rsp_t led_rsp;
  bus_req_t key_req;
  bus_rsp_t key_rsp;

  bus_decoder bus_decoder_inst (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_req     (i_dbus),
    .o_rsp     (o_dbus),
    .o_mem_req (mem_req),
    .i_mem_rsp (mem_rsp),
    .o_led_req (led_req),
    .i_led_rsp (led_rsp),
    .o_key_req (key_req),
    .i_key_rsp (key_rsp)
  );

  // Instruction bus has its own read port
  soc_mem #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) soc_mem_inst (
    .clk    (clk),
    .i_ireq (i_ibus),
    .o_irsp (o_ibus),
    .i_dreq (mem_req),
    .o_drsp (mem_rsp)
  );

  led_port led_port_inst (
    .clk   (clk),
    .i_rst (i_rst),
    .i_req (led_req),
    .o_rsp (led_rsp),
    .o_led (o_led)
  );

  key_port #(
    .NUM_KEYS (NUM_KEYS)
  ) key_port_inst (
    .clk   (clk),
    .i_rst (i_rst),
    .i_key (i_key),
    .i_req (key_req),
    .o_rsp (key_rsp)
  );

endmodule

`default_nettype wire

// ==== sim/soc_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top_tb;

  import bus_pkg::*;
  import soc_map_pkg::*;

  localparam int    MEM_ADDR_BITS = 12;
  localparam int    NUM_KEYS      = 2;
  localparam int    MAX_LINES     = 128;
  localparam int    KEY_SETTLE    = 4;
  localparam int    HALF_PERIOD   = 20;
  localparam string DATA_FILE     = "sim/soc_testdata.txt";

  logic                clk;
  logic                i_rst;
  bus_req_t            i_ibus;
  bus_req_t            i_dbus;
  bus_rsp_t            o_ibus;
  bus_rsp_t            o_dbus;
  logic [NUM_KEYS-1:0] i_key;
  logic [LED_W-1:0]    o_led;

  // One entry per transaction line of the data file
  logic [7:0]            vec_bus   [MAX_LINES];
  logic [7:0]            vec_op    [MAX_LINES];
  logic [BUS_ADDR_W-1:0] vec_addr  [MAX_LINES];
  logic [BUS_DATA_W-1:0] vec_wdata [MAX_LINES];
  logic [BUS_MASK_W-1:0] vec_mask  [MAX_LINES];
  logic [NUM_KEYS-1:0]   vec_key   [MAX_LINES];
  logic [BUS_DATA_W-1:0] vec_exp   [MAX_LINES];

  int                    n_lines;
  bit                    loaded;
  int                    err_cnt;
  int                    test_cnt;
  int                    test_fail;
  integer                seed;
  logic [BUS_DATA_W-1:0] last_rnd;
  bit                    pend;
  int                    pend_idx;
  int                    pend_err;
  logic [BUS_DATA_W-1:0] pend_exp;

  soc_top #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS),
    .NUM_KEYS      (NUM_KEYS)
  ) soc_top_inst (
    .clk    (clk),
    .i_rst  (i_rst),
    .i_ibus (i_ibus),
    .o_ibus (o_ibus),
    .i_dbus (i_dbus),
    .o_dbus (o_dbus),
    .i_key  (i_key),
    .o_led  (o_led)
  );

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  task automatic load_vectors(output bit ok);
    integer fd;
    int c;
    int n;
    logic [7:0]  op;
    logic [31:0] a, w, m, k, e;
    ok = 1'b0;
    n_lines = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd != 0)
    begin
      c = 0;
      while (c != -1 && n_lines < MAX_LINES)
      begin
        c = $fgetc(fd);
        if (c == "#")
        begin
          while (c != "\n" && c != -1)
            c = $fgetc(fd);
        end
        else if (c == "I" || c == "D")
        begin
          n = $fscanf(fd, " %c %h %h %h %h %h", op, a, w, m, k, e);
          if (n == 6)
          begin
            vec_bus[n_lines]   = c[7:0];
            vec_op[n_lines]    = op;
            vec_addr[n_lines]  = a;
            vec_wdata[n_lines] = w;
            vec_mask[n_lines]  = m[BUS_MASK_W-1:0];
            vec_key[n_lines]   = k[NUM_KEYS-1:0];
            vec_exp[n_lines]   = e;
            n_lines++;
          end
        end
      end
      $fclose(fd);
      ok = (n_lines > 0);
    end
  endtask

  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string name);
    if (got.ack !== exp.ack)
    begin
      err_cnt++;
      $display("FAIL @ %0t: %s ack is %b, expected %b", $time, name, got.ack, exp.ack);
    end
    else if (exp.ack && got.rdata !== exp.rdata)
    begin
      err_cnt++;
      $display("FAIL @ %0t: %s rdata is %h, expected %h", $time, name, got.rdata, exp.rdata);
    end
  endtask

  task automatic check_led(input logic [LED_W-1:0] exp);
    if (o_led !== exp)
    begin
      err_cnt++;
      $display("FAIL @ %0t: o_led is %h, expected %h", $time, o_led, exp);
    end
  endtask

  // Drive one request; the expected rdata is fixed here
  task automatic issue(input int i);
    bus_req_t req;
    req = '0;
    req.req = 1'b1;
    req.addr = vec_addr[i];
    req.wr_mask = vec_mask[i];
    case (vec_op[i])
      "W":
      begin
        req.op = OP_WRITE;
        req.wdata = vec_wdata[i];
        pend_exp = '0;
      end
      "N":
      begin
        last_rnd = $random(seed);
        req.op = OP_WRITE;
        req.wdata = last_rnd;
        pend_exp = '0;
      end
      "C":
      begin
        req.op = OP_READ;
        pend_exp = last_rnd;
      end
      default:
      begin
        req.op = OP_READ;
        pend_exp = vec_exp[i];
      end
    endcase
    if (vec_bus[i] == "I")
      i_ibus = req;
    else
      i_dbus = req;
    pend = 1'b1;
    pend_idx = i;
    pend_err = err_cnt;
  endtask

  // Ack must show on the edge right after req, and never otherwise
  task automatic next_cycle();
    bus_rsp_t exp_i;
    bus_rsp_t exp_d;
    bit       is_wr;
    @(negedge clk);
    exp_i = '0;
    exp_d = '0;
    if (pend && vec_bus[pend_idx] == "I")
      exp_i = {1'b1, pend_exp};
    if (pend && vec_bus[pend_idx] == "D")
      exp_d = {1'b1, pend_exp};
    check_rsp(o_ibus, exp_i, "ibus");
    check_rsp(o_dbus, exp_d, "dbus");
    if (pend)
    begin
      is_wr = (vec_op[pend_idx] == "W") || (vec_op[pend_idx] == "N");
      if (vec_bus[pend_idx] == "D" && is_wr)
        check_led(vec_exp[pend_idx][LED_W-1:0]);
      test_cnt++;
      if (err_cnt != pend_err)
        test_fail++;
      $display("txn %0d %c %c %h: %s", pend_idx, vec_bus[pend_idx], vec_op[pend_idx],
               vec_addr[pend_idx], (err_cnt == pend_err) ? "ok" : "failed");
    end
    pend = 1'b0;
    i_ibus = '0;
    i_dbus = '0;
  endtask

  initial
  begin
    bit ok;
    i_rst = 1'b1;
    i_ibus = '0;
    i_dbus = '0;
    i_key = '1;
    seed = 32'hbf74;
    err_cnt = 0;
    test_cnt = 0;
    test_fail = 0;
    pend = 1'b0;
    loaded = 1'b0;
    load_vectors(ok);
    if (!ok)
    begin
      $display("Could not read any transactions from %s", DATA_FILE);
      $display("TB FAILED");
      $finish;
    end
    else
    begin
      loaded = 1'b1;
      repeat (16) @(negedge clk);
      i_rst = 1'b0;
      check_led('0);
      for (int i = 0; i < n_lines; i++)
      begin
        next_cycle();
        // Keys need the synchronizer and edge stage to settle
        if (vec_key[i] !== i_key)
        begin
          i_key = vec_key[i];
          repeat (KEY_SETTLE) next_cycle();
        end
        issue(i);
      end
      next_cycle();
      $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0)
        $display("TB PASSED");
      else
        $display("TB FAILED");
      $finish;
    end
  end

  // Watchdog sized from the number of transactions
  initial
  begin
    int limit;
    wait (loaded);
    limit = n_lines * 10 + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/soc_testdata.txt ====
# bus(I/D) op addr wdata mask key(pins, active low) expect
# op: R read, W write, N random write, C read of last random; expect is rdata, or LED after a D write
# Memory full-word and partial writes
D W 00000000 11223344 f 3 00
D W 00000004 a5a55a5a f 3 00
D R 00000000 00000000 0 3 11223344
D R 00000004 00000000 0 3 a5a55a5a
D W 00000000 deadbeef 1 3 00
D R 00000000 00000000 0 3 112233ef
D W 00000000 cafef00d 6 3 00
D R 00000000 00000000 0 3 11fef0ef
D W 00000008 00000000 f 3 00
D W 00000008 ffffffff 8 3 00
D R 00000008 00000000 0 3 ff000000
D R 00004004 00000000 0 3 a5a55a5a
D N 00000010 00000000 f 3 00
D C 00000010 00000000 0 3 00000000
# Instruction fetch interleaved with data reads
I R 00000000 00000000 0 3 11fef0ef
I R 00000004 00000000 0 3 a5a55a5a
D R 00000008 00000000 0 3 ff000000
I C 00000010 00000000 0 3 00000000
D R 00000004 00000000 0 3 a5a55a5a
# LED register
D W 80000000 000000a5 1 3 a5
D R 80000000 00000000 0 3 000000a5
D W 80000010 0000003c e 3 a5
D R 80000010 00000000 0 3 000000a5
D W 8000000c 12345678 f 3 78
D R 80000000 00000000 0 3 00000078
# Key level and press latch
D R c0000000 00000000 0 2 00000001
D R c0000000 00000000 0 3 00000000
D R c0000004 00000000 0 3 00000001
D R c0000000 00000000 0 1 00000002
D R c0000004 00000000 0 3 00000003
D W c0000004 00000001 1 3 78
D R c0000004 00000000 0 3 00000002
D W c0000004 00000002 1 3 78
D R c0000004 00000000 0 3 00000000
# Unmapped region
D R 40000000 00000000 0 3 00000000
D W 40000010 ffffffff f 3 78
D R 40000010 00000000 0 3 00000000
D C 00000010 00000000 0 3 00000000
I R 00000008 00000000 0 3 ff000000

// ==== sources.f ====
logic/bus_pkg.sv
logic/soc_map_pkg.sv
logic/bus_decoder.sv
logic/soc_mem.sv
logic/led_port.sv
logic/key_port.sv
logic/soc_top.sv
sim/soc_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= soc_top_tb
RTL_TOP   ?= soc_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
